/* hw/ahb_sram_cfg.svh */
/*
 * AHB SRAM slave configuration
 * Bus widths, SRAM size and the widths used by burst arithmetic
 */

`ifndef AHB_SRAM_CFG_SVH
`define AHB_SRAM_CFG_SVH

// AHB data and address bus widths
`define AHB_DWIDTH 32
`define AHB_AWIDTH 32

// Byte address bits that reach the SRAM (1024 words)
`define MEM_AWIDTH 12

// Low address bits covered by wrap arithmetic
`define WRAP_BITS 11

// Counts up to 16 beats
`define BEAT_CNT_W 5

// Word count follows from the byte address width
`define MEM_WORDS (1 << (`MEM_AWIDTH - 2))

`endif

/* hw/ahb_sram_pkg.sv */
/*
 * AHB SRAM slave types
 * AHB transfer, burst and size encodings and the slave FSM states
 */

`default_nettype none

package ahb_sram_pkg;

   // HTRANS encoding
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // HBURST encoding, wrap codes have bit 0 clear
   typedef enum logic [2:0] {
      SINGLE = 3'b000,
      INCR   = 3'b001,
      WRAP4  = 3'b010,
      INCR4  = 3'b011,
      WRAP8  = 3'b100,
      INCR8  = 3'b101,
      WRAP16 = 3'b110,
      INCR16 = 3'b111
   } hburst_e;

   // HSIZE, bytes per beat is 2**code
   typedef enum logic [2:0] {
      BYTE  = 3'b000,
      HALF  = 3'b001,
      WORD  = 3'b010,
      DWORD = 3'b011,
      QWORD = 3'b100,
      OWORD = 3'b101,
      W512  = 3'b110,
      W1024 = 3'b111
   } hsize_e;

   // Slave data phase states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'b00,
      ST_WRITE = 2'b01,
      ST_READ  = 2'b10
   } slave_state_e;

   // Only response this slave gives
   localparam logic HRESP_OKAY = 1'b0;

endpackage

`default_nettype wire

/* hw/sram_if.sv */
/*
 * SRAM port bundle
 * Control, address, byte lanes and data between the slave and the array
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

interface sram_if (
   input logic HCLK
);

   logic                       wen;
   logic                       ren;
   logic [`AHB_DWIDTH-1:0]     wdata;
   // Byte address, word index above the two lane bits
   logic [`MEM_AWIDTH-1:0]     addr;
   logic [`AHB_DWIDTH/8-1:0]   byteen;
   logic [`AHB_DWIDTH-1:0]     rdata;

   // Slave FSM side
   modport ctrl (output wen, ren, wdata);

   // Address generator side
   modport addr_src (output addr);

   // Lane decoder, clock only for checking
   modport lanes (input HCLK, wen, addr, output byteen);

   // Memory array side
   modport mem (input wen, ren, wdata, addr, byteen, output rdata);

endinterface

`default_nettype wire

/* hw/ahb_slave_fsm.sv */
/*
 * AHB-Lite slave control
 * Accepts transfers, runs the write/read FSM, inserts the single
 * read wait state and latches size and direction
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_slave_fsm
   import ahb_sram_pkg::*;
(
   input  logic                   HCLK,
   input  logic                   aresetn,
   input  logic                   hsel,
   input  logic                   hreadyin,
   input  htrans_e                htrans,
   input  logic                   hwrite,
   input  hsize_e                 hsize,
   output logic                   hreadyout,
   output logic                   cmd_load,
   output logic                   beat_step,
   output logic                   rd_path,
   output hsize_e                 size_d,
   sram_if.ctrl                   mem_ctl,
   input  logic [`AHB_DWIDTH-1:0] hwdata
);

   slave_state_e state_q;
   slave_state_e state_d;
   logic         accept;
   logic         leave;
   logic         rd_wait_q;
   logic         hwrite_q;

   ////////////////////////////////////////////////////////////
   // Transfer decode

   // Address phase taken by this slave
   assign accept = hsel & hreadyin & hreadyout & ((htrans == NONSEQ) | (htrans == SEQ));
   assign cmd_load = accept & (htrans == NONSEQ);

   // SEQ held through the read wait state still steps,
   // the read address runs one beat ahead of the bus
   assign beat_step = (accept | (rd_wait_q & hsel)) & (htrans == SEQ);

   // Bus idle, or a new transfer for another slave
   assign leave = (htrans == IDLE) | ((htrans == NONSEQ) & ~hsel);

   ////////////////////////////////////////////////////////////
   // Data phase FSM

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept)
               state_d = hwrite ? ST_WRITE : ST_READ;
         end
         ST_WRITE, ST_READ: begin
            if (leave)
               state_d = ST_IDLE;
            else if (accept)
               state_d = hwrite ? ST_WRITE : ST_READ;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         state_q   <= ST_IDLE;
         rd_wait_q <= 1'b0;
         hwrite_q  <= 1'b0;
         size_d    <= WORD;
      end else begin
         state_q   <= state_d;
         // New read, SRAM needs one cycle before data
         rd_wait_q <= cmd_load & ~hwrite;
         if (accept) begin
            size_d   <= hsize;
            hwrite_q <= hwrite;
         end
      end
   end

   // SRAM strobes follow the data phase
   assign mem_ctl.wen   = (state_q == ST_WRITE);
   assign mem_ctl.ren   = (state_q == ST_READ);
   assign mem_ctl.wdata = hwdata;

   assign hreadyout = ~rd_wait_q;
   // Read address only while the last transfer was a read
   assign rd_path   = ~hwrite_q;

   // No BUSY beats towards this slave
   a_no_busy : assert property (@(posedge HCLK) disable iff (!aresetn)
      hsel |-> (htrans != BUSY))
      else $error("BUSY transfer issued to the SRAM slave");

endmodule

`default_nettype wire

/* hw/burst_addr_gen.sv */
/*
 * Burst address generator
 * Registered write address, internal read address with increment
 * and wrap, beat counting and SRAM address select
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

module burst_addr_gen
   import ahb_sram_pkg::*;
(
   input  logic                   HCLK,
   input  logic                   aresetn,
   input  logic [`MEM_AWIDTH-1:0] haddr,
   input  hburst_e                hburst,
   input  hsize_e                 hsize,
   input  logic                   cmd_load,
   input  logic                   beat_step,
   input  logic                   rd_path,
   sram_if.addr_src               mem_addr
);

   logic [`MEM_AWIDTH-1:0] waddr_q;
   logic [`MEM_AWIDTH-1:0] raddr_q;
   logic [`MEM_AWIDTH-1:0] raddr_nxt;
   logic [`WRAP_BITS:0]    span_bytes;
   logic [7:0]             size_bytes;
   logic [`WRAP_BITS-1:0]  wrap_mask_q;
   logic [7:0]             step_q;
   logic                   wrap_q;
   logic [`BEAT_CNT_W-1:0] beat_lim_d;
   logic [`BEAT_CNT_W-1:0] beat_lim_q;
   logic [`BEAT_CNT_W-1:0] beat_cnt_q;
   logic                   at_top;
   logic                   can_step;

   ////////////////////////////////////////////////////////////
   // Burst attributes

   // Span is 4/8/16 beats from HBURST[2:1], scaled by size
   assign size_bytes = 8'd1 << hsize;
   assign span_bytes = ((`WRAP_BITS+1)'(2) << hburst[2:1]) << hsize;

   always_comb begin
      case (hburst)
         SINGLE:        beat_lim_d = `BEAT_CNT_W'(1);
         WRAP4, INCR4:  beat_lim_d = `BEAT_CNT_W'(4);
         WRAP8, INCR8:  beat_lim_d = `BEAT_CNT_W'(8);
         WRAP16, INCR16: beat_lim_d = `BEAT_CNT_W'(16);
         // Zero marks undefined length
         default:       beat_lim_d = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Read address

   // Top beat of the span has every mask bit set
   assign at_top   = wrap_q & ((raddr_q[`WRAP_BITS-1:0] & wrap_mask_q) == wrap_mask_q);
   assign can_step = (beat_lim_q == '0) | (beat_cnt_q < beat_lim_q);

   always_comb begin
      if (at_top)
         raddr_nxt = {raddr_q[`MEM_AWIDTH-1:`WRAP_BITS], raddr_q[`WRAP_BITS-1:0] & ~wrap_mask_q};
      else
         raddr_nxt = raddr_q + `MEM_AWIDTH'(step_q);
   end

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         raddr_q     <= '0;
         wrap_mask_q <= '0;
         step_q      <= 8'd4;
         wrap_q      <= 1'b0;
         beat_lim_q  <= '0;
         beat_cnt_q  <= '0;
      end else if (cmd_load) begin
         raddr_q     <= haddr;
         wrap_mask_q <= `WRAP_BITS'(span_bytes - size_bytes);
         step_q      <= size_bytes;
         wrap_q      <= (hburst == WRAP4) | (hburst == WRAP8) | (hburst == WRAP16);
         beat_lim_q  <= beat_lim_d;
         beat_cnt_q  <= `BEAT_CNT_W'(1);
      end else if (beat_step && can_step) begin
         raddr_q <= raddr_nxt;
         if (beat_lim_q != '0)
            beat_cnt_q <= beat_cnt_q + 1'b1;
      end
   end

   // Write data phase uses last cycle's HADDR
   always_ff @(posedge HCLK) begin
      waddr_q <= haddr;
   end

   assign mem_addr.addr = rd_path ? raddr_q : waddr_q;

endmodule

`default_nettype wire

/* hw/byte_lane_decode.sv */
/*
 * Byte lane decoder
 * Write enables per byte from the latched size and low address bits
 */

`default_nettype none

module byte_lane_decode
   import ahb_sram_pkg::*;
(
   input  hsize_e     size_d,
   sram_if.lanes      lanes
);

   logic [3:0] lane_sel;

   ////////////////////////////////////////////////////////////
   // Lane select

   always_comb begin
      case (size_d)
         // One lane from addr[1:0]
         BYTE: lane_sel = 4'b0001 << lanes.addr[1:0];
         // Lower or upper half from addr[1]
         HALF: lane_sel = lanes.addr[1] ? 4'b1100 : 4'b0011;
         // Word and wider take the full bus
         default: lane_sel = 4'b1111;
      endcase
   end

   // Only a write data phase opens any lane
   assign lanes.byteen = lane_sel & {4{lanes.wen}};

   // Halfword writes sit on a halfword boundary
   a_half_aligned : assert property (@(posedge lanes.HCLK)
      (lanes.wen && (size_d == HALF)) |-> (lanes.addr[0] == 1'b0))
      else $error("halfword write not aligned");

   // Bus is one word wide
   a_size_fits : assert property (@(posedge lanes.HCLK)
      lanes.wen |-> (size_d inside {BYTE, HALF, WORD}))
      else $error("write wider than the data bus");

endmodule

`default_nettype wire

/* hw/sram_array.sv */
/*
 * On-chip SRAM array
 * Word memory with byte-enabled writes and a registered read port
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

module sram_array (
   input  logic  HCLK,
   sram_if.mem   mem
);

   logic [`AHB_DWIDTH-1:0] ram_q [`MEM_WORDS];
   logic [`MEM_AWIDTH-3:0] word_idx;

   // Drop the lane bits
   assign word_idx = mem.addr[`MEM_AWIDTH-1:2];

   ////////////////////////////////////////////////////////////
   // Write port

   always_ff @(posedge HCLK) begin
      if (mem.wen) begin
         for (int i = 0; i < `AHB_DWIDTH/8; i++) begin
            // Disabled lanes keep their old byte
            if (mem.byteen[i])
               ram_q[word_idx][8*i +: 8] <= mem.wdata[8*i +: 8];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Read port

   // Data one cycle after ren, held otherwise
   always_ff @(posedge HCLK) begin
      if (mem.ren)
         mem.rdata <= ram_q[word_idx];
   end

endmodule

`default_nettype wire

/* hw/ahb_sram_top.sv */
/*
 * AHB-Lite SRAM slave top
 * Slave control, burst addressing, lane decode and the SRAM array
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_sram_top
   import ahb_sram_pkg::*;
(
   input  logic                   HCLK,
   input  logic                   aresetn,
   input  logic                   hsel,
   input  logic                   hreadyin,
   input  logic [1:0]             htrans,
   input  logic [2:0]             hburst,
   input  logic [2:0]             hsize,
   input  logic                   hwrite,
   input  logic [`AHB_AWIDTH-1:0] haddr,
   input  logic [`AHB_DWIDTH-1:0] hwdata,
   output logic                   hreadyout,
   output logic                   hresp,
   output logic [`AHB_DWIDTH-1:0] hrdata
);

   hsize_e size_d;
   logic   cmd_load;
   logic   beat_step;
   logic   rd_path;

   // SRAM side bundle
   sram_if u_mem_bus (.HCLK(HCLK));

   ahb_slave_fsm u_fsm (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .htrans    (htrans_e'(htrans)),
      .hwrite    (hwrite),
      .hsize     (hsize_e'(hsize)),
      .hreadyout (hreadyout),
      .cmd_load  (cmd_load),
      .beat_step (beat_step),
      .rd_path   (rd_path),
      .size_d    (size_d),
      .mem_ctl   (u_mem_bus.ctrl),
      .hwdata    (hwdata)
   );

   // Only the SRAM byte address bits are decoded here
   burst_addr_gen u_addr (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .haddr     (haddr[`MEM_AWIDTH-1:0]),
      .hburst    (hburst_e'(hburst)),
      .hsize     (hsize_e'(hsize)),
      .cmd_load  (cmd_load),
      .beat_step (beat_step),
      .rd_path   (rd_path),
      .mem_addr  (u_mem_bus.addr_src)
   );

   byte_lane_decode u_lanes (
      .size_d (size_d),
      .lanes  (u_mem_bus.lanes)
   );

   sram_array u_sram (
      .HCLK (HCLK),
      .mem  (u_mem_bus.mem)
   );

   assign hrdata = u_mem_bus.rdata;
   assign hresp  = HRESP_OKAY;

endmodule

`default_nettype wire

/* tests/tb_ahb_sram.sv */
/*
 * AHB-Lite SRAM slave testbench
 * Directed AHB master bursts against a byte-level reference memory
 */

`default_nettype none

`include "ahb_sram_cfg.svh"

module tb_ahb_sram
   import ahb_sram_pkg::*;
();

   // Well above the few hundred cycles all tests take together
   localparam int TIMEOUT_CYCLES = 4000;

   // One AHB beat as the master presents it
   typedef struct packed {
      logic [`AHB_AWIDTH-1:0] addr;
      logic                   wr;
      htrans_e                trans;
      hburst_e                burst;
      hsize_e                 size;
      logic [`AHB_DWIDTH-1:0] data;
   } beat_t;

   logic                   HCLK = 1'b0;
   logic                   aresetn;
   logic                   hsel;
   htrans_e                htrans;
   hburst_e                hburst;
   hsize_e                 hsize;
   logic                   hwrite;
   logic [`AHB_AWIDTH-1:0] haddr;
   logic [`AHB_DWIDTH-1:0] hwdata;
   logic                   hreadyout;
   logic                   hresp;
   logic [`AHB_DWIDTH-1:0] hrdata;

   beat_t      beat_q [$];
   logic [7:0] ref_mem [0:(1 << `MEM_AWIDTH)-1];
   int         seed = 93;
   int         data_errors = 0;
   int         proto_errors = 0;
   int         cycles = 0;

   // Single slave, so HREADY comes straight back
   ahb_sram_top dut (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .hsel      (hsel),
      .hreadyin  (hreadyout),
      .htrans    (htrans),
      .hburst    (hburst),
      .hsize     (hsize),
      .hwrite    (hwrite),
      .haddr     (haddr),
      .hwdata    (hwdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .hrdata    (hrdata)
   );

   always #4 HCLK = ~HCLK;

   always @(posedge HCLK) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a transfer never completed", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////
   // Reference model

   // AHB address of beat k, wrap spans are beats times size
   function automatic logic [31:0] beat_addr(input logic [31:0] start, input hburst_e burst,
                                             input hsize_e size, input int k);
      int          bytes;
      int          span;
      logic [31:0] base;
      bytes = 1 << size;
      case (burst)
         WRAP4:   span = 4 * bytes;
         WRAP8:   span = 8 * bytes;
         WRAP16:  span = 16 * bytes;
         default: span = 0;
      endcase
      if (span == 0)
         return start + k * bytes;
      base = start & ~(span - 1);
      return base + ((start - base + k * bytes) % span);
   endfunction

   // Lanes a write of this size touches
   function automatic logic lane_hit(input logic [1:0] off, input hsize_e size, input int lane);
      case (size)
         BYTE:    return lane == off;
         HALF:    return (lane / 2) == off[1];
         default: return 1'b1;
      endcase
   endfunction

   function automatic logic [31:0] model_word(input logic [31:0] a);
      return {ref_mem[{a[11:2], 2'd3}], ref_mem[{a[11:2], 2'd2}],
              ref_mem[{a[11:2], 2'd1}], ref_mem[{a[11:2], 2'd0}]};
   endfunction

   //////////////////////////////////////////////////////////////
   // AHB master

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else begin
         data_errors++;
         $display("ERR %s: expected %08h, got %08h", name, exp, act);
      end
   endtask

   // Builds the beats, writes update the model, reads take their expected word
   task automatic queue_burst(input logic wr, input hburst_e burst, input hsize_e size,
                              input logic [31:0] start, input int beats);
      beat_t b;
      for (int k = 0; k < beats; k++) begin
         b.addr  = beat_addr(start, burst, size, k);
         b.wr    = wr;
         b.trans = (k == 0) ? NONSEQ : SEQ;
         b.burst = burst;
         b.size  = size;
         if (wr) begin
            b.data = $random(seed);
            for (int lane = 0; lane < 4; lane++) begin
               if (lane_hit(b.addr[1:0], size, lane))
                  ref_mem[{b.addr[11:2], lane[1:0]}] = b.data[8*lane +: 8];
            end
         end else begin
            b.data = model_word(b.addr);
         end
         beat_q.push_back(b);
      end
   endtask

   task automatic drive_beat(input beat_t b);
      htrans <= b.trans;
      haddr  <= b.addr;
      hwrite <= b.wr;
      hburst <= b.burst;
      hsize  <= b.size;
   endtask

   // Address and data phases overlap, each moves on a ready edge
   task automatic run_bus(input string name);
      int                     n;
      int                     a;
      int                     d;
      logic                   rdy;
      logic                   exp_wait;
      logic [`AHB_DWIDTH-1:0] rd;
      n        = beat_q.size();
      a        = 0;
      d        = -1;
      exp_wait = 1'b0;
      @(posedge HCLK);
      drive_beat(beat_q[0]);
      while (a < n || d >= 0) begin
         // Mid-cycle sample of the response
         @(negedge HCLK);
         rdy = hreadyout;
         rd  = hrdata;
         check_word({name, " hresp"}, 32'd0, {31'd0, hresp});
         assert (rdy === !exp_wait)
         else begin
            proto_errors++;
            if (exp_wait)
               $display("%s: wait state missing before the first read data", name);
            else
               $display("%s: unexpected wait state at beat %0d", name, d);
         end
         @(posedge HCLK);
         exp_wait = 1'b0;
         if (rdy) begin
            if (d >= 0 && !beat_q[d].wr)
               check_word(name, beat_q[d].data, rd);
            if (a < n) begin
               d = a;
               a++;
               // New read costs exactly one cycle
               exp_wait = !beat_q[d].wr && (beat_q[d].trans == NONSEQ);
               if (beat_q[d].wr)
                  hwdata <= beat_q[d].data;
               if (a < n)
                  drive_beat(beat_q[a]);
               else
                  htrans <= IDLE;
            end else begin
               d = -1;
            end
         end
      end
      beat_q.delete();
   endtask

   task automatic ahb_write_burst(input string name, input hburst_e burst, input hsize_e size,
                                  input logic [31:0] start, input int beats);
      queue_burst(1'b1, burst, size, start, beats);
      run_bus(name);
   endtask

   task automatic ahb_read_burst(input string name, input hburst_e burst, input hsize_e size,
                                 input logic [31:0] start, input int beats);
      queue_burst(1'b0, burst, size, start, beats);
      run_bus(name);
   endtask

   //////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_reset();
      for (int i = 0; i < 8; i++) begin
         @(negedge HCLK);
         check_word("reset hreadyout", 32'd1, {31'd0, hreadyout});
         check_word("reset hresp", 32'd0, {31'd0, hresp});
      end
      @(posedge HCLK);
      aresetn <= 1'b1;
      hsel    <= 1'b1;
      @(negedge HCLK);
      check_word("reset hreadyout", 32'd1, {31'd0, hreadyout});
      ahb_write_burst("reset", SINGLE, WORD, 32'h010, 1);
      ahb_read_burst("reset", SINGLE, WORD, 32'h010, 1);
   endtask

   task automatic test_byte_half();
      logic [31:0] w;
      for (int off = 0; off < 4; off++) begin
         w = 32'h100 + 32'(8 * off);
         ahb_write_burst("byte_lane", SINGLE, WORD, w, 1);
         ahb_write_burst("byte_lane", SINGLE, BYTE, w + 32'(off), 1);
         ahb_read_burst("byte_lane", SINGLE, WORD, w, 1);
      end
      for (int off = 0; off < 4; off += 2) begin
         w = 32'h140 + 32'(4 * off);
         ahb_write_burst("half_lane", SINGLE, WORD, w, 1);
         ahb_write_burst("half_lane", SINGLE, HALF, w + 32'(off), 1);
         ahb_read_burst("half_lane", SINGLE, WORD, w, 1);
      end
   endtask

   task automatic test_incr();
      ahb_write_burst("incr4", INCR4, WORD, 32'h200, 4);
      ahb_read_burst("incr4", INCR4, WORD, 32'h200, 4);
      ahb_write_burst("incr8", INCR8, WORD, 32'h300, 8);
      ahb_read_burst("incr8", INCR8, WORD, 32'h300, 8);
      ahb_write_burst("incr16", INCR16, WORD, 32'h400, 16);
      ahb_read_burst("incr16", INCR16, WORD, 32'h400, 16);
   endtask

   task automatic test_wrap();
      ahb_write_burst("wrap_fill", INCR16, WORD, 32'h500, 16);
      ahb_read_burst("wrap4", WRAP4, WORD, 32'h508, 4);
      ahb_read_burst("wrap8", WRAP8, WORD, 32'h514, 8);
      // Halfword span is 8 bytes
      ahb_read_burst("wrap4_half", WRAP4, HALF, 32'h506, 4);
   endtask

   task automatic test_undef_len();
      int len;
      for (int i = 0; i < 3; i++) begin
         len = 1 + ({$random(seed)} % 16);
         ahb_write_burst("incr_undef", INCR, WORD, 32'h600 + 32'(64 * i), len);
         ahb_read_burst("incr_undef", INCR, WORD, 32'h600 + 32'(64 * i), len);
      end
      // Last write data phase shares its cycle with the read address phase
      queue_burst(1'b1, SINGLE, WORD, 32'h700, 1);
      queue_burst(1'b0, SINGLE, WORD, 32'h700, 1);
      run_bus("write_read");
      queue_burst(1'b1, INCR, WORD, 32'h740, 4);
      queue_burst(1'b0, INCR, WORD, 32'h740, 4);
      run_bus("write_read_incr");
   endtask

   initial begin
      aresetn = 1'b0;
      hsel    = 1'b0;
      htrans  = IDLE;
      hburst  = SINGLE;
      hsize   = WORD;
      hwrite  = 1'b0;
      haddr   = '0;
      hwdata  = '0;
      test_reset();
      test_byte_half();
      test_incr();
      test_wrap();
      test_undef_len();
      repeat (2) @(posedge HCLK);
      $display("Data errors: %0d, protocol errors: %0d", data_errors, proto_errors);
      if (data_errors == 0 && proto_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/ahb_sram_pkg.sv
hw/sram_if.sv
hw/ahb_slave_fsm.sv
hw/burst_addr_gen.sv
hw/byte_lane_decode.sv
hw/sram_array.sv
hw/ahb_sram_top.sv
tests/tb_ahb_sram.sv

/* Bender.yml */
package:
  name: ahb_sram

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ahb_sram_pkg.sv
      - hw/sram_if.sv
      - hw/ahb_slave_fsm.sv
      - hw/burst_addr_gen.sv
      - hw/byte_lane_decode.sv
      - hw/sram_array.sv
      - hw/ahb_sram_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_ahb_sram.sv
